//--- tag_defs.svh
`ifndef TAG_DEFS_SVH
`define TAG_DEFS_SVH

// Number of heap entries, also the tag space
`define TT_N_TAGS       16

// Tag width, log2 of the entry count
`define TT_TAG_BITS     4

// Client context stored per outstanding request
`define TT_CTX_BITS     16

// Request address and response data widths
`define TT_ADDR_BITS    32
`define TT_DATA_BITS    32

// Heap reports full once free slots drop to this count
`define TT_MIN_FREE     1

`endif

//--- tag_pkg.sv
`include "tag_defs.svh"

package tag_pkg;

    // One outstanding-request tag
    typedef logic [`TT_TAG_BITS-1:0] tag_t;

    // Request as seen from the client side
    typedef struct packed {
        logic [`TT_CTX_BITS-1:0]  ctx;
        logic [`TT_ADDR_BITS-1:0] addr;
    } client_req_t;

    // Request toward the memory fabric, context replaced by a tag
    typedef struct packed {
        tag_t                     tag;
        logic [`TT_ADDR_BITS-1:0] addr;
    } fabric_req_t;

    // Fabric response, may come back in any order
    typedef struct packed {
        tag_t                     tag;
        logic [`TT_DATA_BITS-1:0] data;
    } fabric_rsp_t;

    // Completion handed back to the client
    typedef struct packed {
        logic [`TT_CTX_BITS-1:0]  ctx;
        logic [`TT_DATA_BITS-1:0] data;
    } completion_t;

endpackage

//--- simple_ram.sv
`timescale 1ns/1ps

module simple_ram
#(
    parameter int N_ENTRIES = 16,
    parameter int DATA_BITS = 16
)
(
    input  logic                         clk,

    // Write port
    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [DATA_BITS-1:0]         wdata,

    // Read port, data one cycle after the address
    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [DATA_BITS-1:0]         rdata
);

    // Storage array, no reset
    logic [DATA_BITS-1:0] mem [N_ENTRIES];

    // Write on the edge
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read
    // A read of the address being written returns the old word
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

//--- tag_heap.sv
`timescale 1ns/1ps

module tag_heap
    import tag_pkg::*;
#(
    parameter int N_ENTRIES      = 16,
    parameter int DATA_BITS      = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Allocate a slot and store the context word there
    input  logic                 enq,
    input  logic [DATA_BITS-1:0] enq_data,
    output logic                 not_full,
    output tag_t                 alloc_tag,

    // Read back the stored word, data on the next cycle
    input  tag_t                 read_tag,
    output logic [DATA_BITS-1:0] read_data,

    // Return a slot to the free list
    input  logic                 free,
    input  tag_t                 free_tag
);

    // Free count holds up to N_ENTRIES-2
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // ======================================================================
    // Data store
    // ======================================================================

    // Context is written at the slot handed out on this cycle
    simple_ram
    #(
        .N_ENTRIES (N_ENTRIES),
        .DATA_BITS (DATA_BITS)
    )
    data_ram
    (
        .clk   (clk),
        .wen   (enq),
        .waddr (alloc_tag),
        .wdata (enq_data),
        .raddr (read_tag),
        .rdata (read_data)
    );

    // ======================================================================
    // Free list
    // ======================================================================

    // Two linked lists in one memory
    // Entry at address X holds the slot that follows X on its list
    tag_t                head_reg [2];
    tag_t                head     [2];
    tag_t                tail     [2];
    logic                head_sel;
    logic                tail_sel;

    // Pop tracking until the next pointer is back
    logic                pop_q;
    logic                pop_qq;
    logic                head_sel_q;
    logic                head_sel_qq;

    // Free list memory ports
    logic                fl_wen;
    tag_t                fl_wdata;
    tag_t                fl_rdata;
    tag_t                fl_next_q;

    // Init walk and free count
    logic                initialized;
    tag_t                init_idx;
    logic [CNT_BITS-1:0] num_free;

    // Hand out the head of the selected list
    assign alloc_tag = head[head_sel];

    // Full below the threshold
    assign not_full = (num_free > CNT_BITS'(MIN_FREE_SLOTS));

    simple_ram
    #(
        .N_ENTRIES (N_ENTRIES),
        .DATA_BITS ($bits(tag_t))
    )
    free_ram
    (
        .clk   (clk),
        .wen   (fl_wen),
        .waddr (tail[tail_sel]),
        .wdata (fl_wdata),
        .raddr (head[head_sel]),
        .rdata (fl_rdata)
    );

    // Second stage on the next pointer, lines up with pop_qq
    always_ff @(posedge clk)
    begin
        fl_next_q <= fl_rdata;
    end

    // New head arrives two cycles after the pop
    // Lists alternate, so the other list serves the cycle in between
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (pop_qq && (head_sel_qq == 1'(i)))
            begin
                head[i] = fl_next_q;
            end
            else
            begin
                head[i] = head_reg[i];
            end
        end
    end

    // Pop side
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pop_q       <= 1'b0;
            pop_qq      <= 1'b0;
            head_sel    <= 1'b0;
            head_sel_q  <= 1'b0;
            head_sel_qq <= 1'b0;
            // Slots 0 and 1 start as the two heads
            head_reg[0] <= tag_t'(0);
            head_reg[1] <= tag_t'(1);
        end
        else
        begin
            pop_q       <= enq;
            pop_qq      <= pop_q;
            head_sel_q  <= head_sel;
            head_sel_qq <= head_sel_q;
            head_reg[0] <= head[0];
            head_reg[1] <= head[1];
            if (enq)
            begin
                head_sel <= ~head_sel;
            end
        end
    end

    // Push side, init walk first and then freed tags
    assign fl_wen   = !initialized || free;
    assign fl_wdata = initialized ? free_tag : init_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail[0]  <= tag_t'(0);
            tail[1]  <= tag_t'(1);
            tail_sel <= 1'b0;
        end
        else if (fl_wen)
        begin
            // Pushed slot becomes the new tail, next push goes to the other list
            tail[tail_sel] <= fl_wdata;
            tail_sel       <= ~tail_sel;
        end
    end

    // Init walk and free count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Walk starts at 2, slots 0 and 1 are already heads
            init_idx    <= tag_t'(2);
            initialized <= 1'b0;
            num_free    <= '0;
        end
        else if (!initialized)
        begin
            init_idx <= init_idx + tag_t'(1);
            if (init_idx == tag_t'(N_ENTRIES - 1))
            begin
                initialized <= 1'b1;
                // Two slots stay reserved so no head runs empty
                num_free    <= CNT_BITS'(N_ENTRIES - 2);
            end
        end
        else if (free && !enq)
        begin
            num_free <= num_free + CNT_BITS'(1);
        end
        else if (enq && !free)
        begin
            num_free <= num_free - CNT_BITS'(1);
        end
    end

endmodule

//--- req_issuer.sv
`timescale 1ns/1ps
`include "tag_defs.svh"

module req_issuer
    import tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Client request port
    input  logic                    req_valid,
    input  client_req_t             req,
    output logic                    req_ready,

    // Fabric request port
    output logic                    mem_req_valid,
    output fabric_req_t             mem_req,
    input  logic                    mem_req_ready,

    // Heap allocation
    output logic                    heap_enq,
    output logic [`TT_CTX_BITS-1:0] heap_ctx,
    input  logic                    heap_not_full,
    input  tag_t                    heap_alloc_tag
);

    logic accept;

    // Outbound register has room when empty or draining this edge
    assign req_ready = heap_not_full && (!mem_req_valid || mem_req_ready);
    assign accept    = req_valid && req_ready;

    // Heap stores the context at the tag it shows now
    assign heap_enq = accept;
    assign heap_ctx = req.ctx;

    // Outbound valid
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (accept)
        begin
            mem_req_valid <= 1'b1;
        end
        else if (mem_req_ready)
        begin
            mem_req_valid <= 1'b0;
        end
    end

    // Outbound payload
    // Held while the fabric stalls
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            mem_req.tag  <= heap_alloc_tag;
            mem_req.addr <= req.addr;
        end
    end

endmodule

//--- rsp_matcher.sv
`timescale 1ns/1ps
`include "tag_defs.svh"

module rsp_matcher
    import tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Fabric response port
    input  logic                    rsp_valid,
    input  fabric_rsp_t             rsp,
    output logic                    rsp_ready,

    // Completion port
    output logic                    cpl_valid,
    output completion_t             cpl,
    input  logic                    cpl_ready,

    // Heap lookup and release
    output tag_t                    heap_read_tag,
    output logic                    heap_free,
    output tag_t                    heap_free_tag,
    input  logic [`TT_CTX_BITS-1:0] heap_read_data
);

    // ======================================================================
    // Stage one, response held while the context read returns
    // ======================================================================

    logic        s1_valid;
    fabric_rsp_t s1_rsp;
    logic        s2_load;
    logic        s1_hold;
    logic        accept;

    // Completion register takes a word when empty or draining
    assign s2_load   = s1_valid && (!cpl_valid || cpl_ready);
    assign s1_hold   = s1_valid && !s2_load;
    assign rsp_ready = !s1_hold;
    assign accept    = rsp_valid && rsp_ready;

    // Read for the incoming tag on the accepting edge
    // While stage one waits, keep re-reading its own tag so the data stays valid
    assign heap_read_tag = s1_hold ? s1_rsp.tag : rsp.tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
        end
        else if (accept)
        begin
            s1_valid <= 1'b1;
        end
        else if (s2_load)
        begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s1_rsp <= rsp;
        end
    end

    // ======================================================================
    // Stage two, completion register
    // ======================================================================

    // Context is captured here, so the tag can go back on the same edge
    assign heap_free     = s2_load;
    assign heap_free_tag = s1_rsp.tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cpl_valid <= 1'b0;
        end
        else if (s2_load)
        begin
            cpl_valid <= 1'b1;
        end
        else if (cpl_ready)
        begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (s2_load)
        begin
            cpl.ctx  <= heap_read_data;
            cpl.data <= s1_rsp.data;
        end
    end

endmodule

//--- tag_tracker_top.sv
`timescale 1ns/1ps
`include "tag_defs.svh"

module tag_tracker_top
    import tag_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Client requests in
    input  logic        req_valid,
    input  client_req_t req,
    output logic        req_ready,

    // Requests out to the fabric
    output logic        mem_req_valid,
    output fabric_req_t mem_req,
    input  logic        mem_req_ready,

    // Responses back from the fabric, any order
    input  logic        rsp_valid,
    input  fabric_rsp_t rsp,
    output logic        rsp_ready,

    // Completions back to the client
    output logic        cpl_valid,
    output completion_t cpl,
    input  logic        cpl_ready
);

    // Producer to heap
    logic                    heap_enq;
    logic [`TT_CTX_BITS-1:0] heap_ctx;
    logic                    heap_not_full;
    tag_t                    heap_alloc_tag;

    // Consumer to heap
    tag_t                    heap_read_tag;
    logic [`TT_CTX_BITS-1:0] heap_read_data;
    logic                    heap_free;
    tag_t                    heap_free_tag;

    req_issuer issuer0
    (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .heap_enq       (heap_enq),
        .heap_ctx       (heap_ctx),
        .heap_not_full  (heap_not_full),
        .heap_alloc_tag (heap_alloc_tag)
    );

    // Context store and tag allocator
    tag_heap
    #(
        .N_ENTRIES      (`TT_N_TAGS),
        .DATA_BITS      (`TT_CTX_BITS),
        .MIN_FREE_SLOTS (`TT_MIN_FREE)
    )
    heap0
    (
        .clk       (clk),
        .reset     (reset),
        .enq       (heap_enq),
        .enq_data  (heap_ctx),
        .not_full  (heap_not_full),
        .alloc_tag (heap_alloc_tag),
        .read_tag  (heap_read_tag),
        .read_data (heap_read_data),
        .free      (heap_free),
        .free_tag  (heap_free_tag)
    );

    rsp_matcher matcher0
    (
        .clk            (clk),
        .reset          (reset),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready),
        .cpl_valid      (cpl_valid),
        .cpl            (cpl),
        .cpl_ready      (cpl_ready),
        .heap_read_tag  (heap_read_tag),
        .heap_free      (heap_free),
        .heap_free_tag  (heap_free_tag),
        .heap_read_data (heap_read_data)
    );

endmodule

//--- tb_tag_tracker.sv
`timescale 1ns/1ps
`include "tag_defs.svh"

module tb_tag_tracker
    import tag_pkg::*;
();

    // Longest run with all phases is well under this
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        reset;
    logic        req_valid;
    client_req_t req;
    logic        req_ready;
    logic        mem_req_valid;
    fabric_req_t mem_req;
    logic        mem_req_ready;
    logic        rsp_valid;
    fabric_rsp_t rsp;
    logic        rsp_ready;
    logic        cpl_valid;
    completion_t cpl;
    logic        cpl_ready;

    // Scoreboard indexed by tag
    logic                    outstanding [`TT_N_TAGS];
    logic [`TT_CTX_BITS-1:0] sb_ctx [`TT_N_TAGS];
    client_req_t             req_q [$];
    tag_t                    issued_q [$];
    completion_t             cpl_q [$];

    int   errors;
    int   cycles;
    int   n_acc;
    int   n_mem;
    int   n_rsp;
    int   n_cpl;
    bit   init_phase;
    bit   rand_bp;
    logic [31:0] bp_state;
    logic [31:0] req_state;
    logic [31:0] rsp_state;

    tag_tracker_top dut0
    (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .cpl_valid     (cpl_valid),
        .cpl           (cpl),
        .cpl_ready     (cpl_ready)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // Reference model and random source
    // ======================================================================

    // Completion carries the stored client context and the fabric data
    function automatic completion_t expected_cpl(input logic [`TT_CTX_BITS-1:0] ctx,
                                                 input logic [`TT_DATA_BITS-1:0] data);
        completion_t c;
        c.ctx  = ctx;
        c.data = data;
        return c;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ======================================================================
    // Checker samples pre-edge values on every rising edge
    // ======================================================================

    always @(posedge clk)
    begin
        client_req_t exp_req;
        completion_t exp_cpl;
        if (!reset)
        begin
            if (init_phase)
            begin
                assert (!req_ready && !mem_req_valid && !cpl_valid)
                else
                begin
                    errors++;
                    $display("FAIL %0t: port active during heap init", $time);
                end
            end
            if (req_valid && req_ready)
            begin
                req_q.push_back(req);
                n_acc++;
            end
            if (mem_req_valid && mem_req_ready)
            begin
                assert (req_q.size() > 0)
                else
                begin
                    errors++;
                    $display("Fabric request appeared with no client request behind it");
                end
                if (req_q.size() > 0)
                begin
                    exp_req = req_q.pop_front();
                    assert (mem_req.addr == exp_req.addr)
                    else
                    begin
                        errors++;
                        $display("FAIL %0t: addr %h, expected %h", $time,
                                 mem_req.addr, exp_req.addr);
                    end
                    assert (!outstanding[mem_req.tag])
                    else
                    begin
                        errors++;
                        $display("FAIL %0t: tag %0d issued twice", $time, mem_req.tag);
                    end
                    outstanding[mem_req.tag] = 1'b1;
                    sb_ctx[mem_req.tag]      = exp_req.ctx;
                    issued_q.push_back(mem_req.tag);
                    n_mem++;
                end
            end
            // Completions first since they belong to older responses
            if (cpl_valid && cpl_ready)
            begin
                assert (cpl_q.size() > 0)
                else
                begin
                    errors++;
                    $display("Completion came out with no response pending");
                end
                if (cpl_q.size() > 0)
                begin
                    exp_cpl = cpl_q.pop_front();
                    assert (cpl == exp_cpl)
                    else
                    begin
                        errors++;
                        $display("FAIL %0t: completion %h, expected %h", $time, cpl, exp_cpl);
                    end
                    n_cpl++;
                end
            end
            if (rsp_valid && rsp_ready)
            begin
                assert (outstanding[rsp.tag])
                else
                begin
                    errors++;
                    $display("FAIL %0t: response for idle tag %0d", $time, rsp.tag);
                end
                cpl_q.push_back(expected_cpl(sb_ctx[rsp.tag], rsp.data));
                outstanding[rsp.tag] = 1'b0;
                n_rsp++;
            end
        end
    end

    // Cycle limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Errors: %0d", errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Random back-pressure on the two ready inputs
    always @(negedge clk)
    begin
        if (rand_bp)
        begin
            bp_state      = xorshift(bp_state);
            mem_req_ready = bp_state[0] | bp_state[1];
            cpl_ready     = bp_state[2] | bp_state[3];
        end
    end

    // ======================================================================
    // Stimulus tasks enter and leave on a falling edge
    // ======================================================================

    task automatic send_req(input int max_wait, output bit taken);
        int waited;
        waited    = 0;
        taken     = 1'b0;
        req_state = xorshift(req_state);
        req.ctx   = req_state[15:0];
        req_state = xorshift(req_state);
        req.addr  = req_state;
        req_valid = 1'b1;
        while (!taken && waited < max_wait)
        begin
            @(posedge clk);
            if (req_ready)
            begin
                taken = 1'b1;
            end
            waited++;
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic issue_burst(input int count, input bit gaps);
        bit taken;
        for (int i = 0; i < count; i++)
        begin
            send_req(MAX_CYCLES, taken);
            if (gaps)
            begin
                repeat (int'(req_state[21:20])) @(negedge clk);
            end
        end
    endtask

    // Answer outstanding tags in shuffled order with random data
    task automatic respond_all(input int count, input bit gaps);
        int idx;
        for (int i = 0; i < count; i++)
        begin
            while (issued_q.size() == 0)
            begin
                @(negedge clk);
            end
            rsp_state = xorshift(rsp_state);
            idx       = int'(rsp_state[15:0]) % issued_q.size();
            rsp.tag   = issued_q[idx];
            issued_q.delete(idx);
            rsp_state = xorshift(rsp_state);
            rsp.data  = rsp_state;
            rsp_valid = 1'b1;
            do
            begin
                @(posedge clk);
            end
            while (!rsp_ready);
            @(negedge clk);
            rsp_valid = 1'b0;
            if (gaps)
            begin
                repeat (int'(rsp_state[9:8])) @(negedge clk);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((cpl_q.size() > 0 || n_rsp != n_acc) && waited < 300)
        begin
            @(negedge clk);
            waited++;
        end
        assert (cpl_q.size() == 0 && n_rsp == n_acc)
        else
        begin
            errors++;
            $display("Completions lost, %0d still pending", cpl_q.size());
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        int init_cycles;
        int taken_cnt;
        bit taken;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        mem_req_ready = 1'b1;
        rsp_valid = 1'b0;
        rsp = '0;
        cpl_ready = 1'b1;
        errors = 0;
        cycles = 0;
        n_acc = 0;
        n_mem = 0;
        n_rsp = 0;
        n_cpl = 0;
        init_phase = 1'b0;
        rand_bp = 1'b0;
        bp_state = 32'd58;
        req_state = xorshift(32'd58);
        rsp_state = xorshift(req_state);
        for (int i = 0; i < `TT_N_TAGS; i++)
        begin
            outstanding[i] = 1'b0;
            sb_ctx[i] = '0;
        end

        // Outputs stay quiet through 4 cycles of reset
        repeat (4)
        begin
            @(negedge clk);
            assert (!req_ready && !mem_req_valid && !cpl_valid)
            else
            begin
                errors++;
                $display("FAIL %0t: port active during reset", $time);
            end
        end
        reset = 1'b0;
        init_phase = 1'b1;
        init_cycles = 0;
        while (!req_ready && init_cycles < 40)
        begin
            @(negedge clk);
            init_cycles++;
        end
        init_phase = 1'b0;
        assert (init_cycles == 14)
        else
        begin
            errors++;
            $display("FAIL %0t: init took %0d cycles, expected 14", $time, init_cycles);
        end

        // Capacity with responses withheld
        taken_cnt = 0;
        for (int i = 0; i < 20; i++)
        begin
            send_req(4, taken);
            taken_cnt = taken_cnt + int'(taken);
        end
        assert (taken_cnt == 13 && !req_ready)
        else
        begin
            errors++;
            $display("FAIL %0t: %0d requests accepted, expected 13", $time, taken_cnt);
        end
        respond_all(13, 1'b0);
        wait_drain();

        // Tag reuse up to full capacity again
        taken_cnt = 0;
        for (int i = 0; i < 13; i++)
        begin
            send_req(8, taken);
            taken_cnt = taken_cnt + int'(taken);
        end
        assert (taken_cnt == 13)
        else
        begin
            errors++;
            $display("FAIL %0t: %0d reused tags accepted, expected 13", $time, taken_cnt);
        end
        respond_all(13, 1'b1);
        wait_drain();

        // Random traffic with back-pressure
        rand_bp = 1'b1;
        fork
            issue_burst(40, 1'b1);
            respond_all(40, 1'b1);
        join
        rand_bp = 1'b0;
        mem_req_ready = 1'b1;
        cpl_ready = 1'b1;
        wait_drain();
        assert (n_cpl == n_acc && n_mem == n_acc && n_acc == 66)
        else
        begin
            errors++;
            $display("FAIL %0t: %0d requests, %0d fabric, %0d completions", $time,
                     n_acc, n_mem, n_cpl);
        end

        $display("Errors: %0d, requests: %0d, completions: %0d", errors, n_acc, n_cpl);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
tag_pkg.sv
simple_ram.sv
tag_heap.sv
req_issuer.sv
rsp_matcher.sv
tag_tracker_top.sv
tb_tag_tracker.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tag tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_tag_tracker -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tag_tracker > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation log has no result line"
    exit 1
fi

exit 0
